//--- project.f
+incdir+source
source/sched_op_pkg.sv
source/sched_bus_pkg.sv
source/dispatch_seq_alloc.sv
source/issue_entry.sv
source/age_issue_picker.sv
source/issue_scheduler.sv
bench/issue_scheduler_asserts.sv
bench/issue_scheduler_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert --top-module issue_scheduler_tb -f project.f -Mdir obj_dir
	@out=$$(./obj_dir/Vissue_scheduler_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

//--- bench/sched_patterns.txt
// grp disp_v | src0 v tag rdy | src1 v tag rdy | dst dead | wb v tag | flush v seq
// expected: disp_ready disp_seq | issue_valid dst seq   (group f ends the run)
1_1_1_01_1_1_02_1_10_0_0_00_0_0_1_0_0_00_0
1_0_0_00_0_0_00_0_00_0_0_00_0_0_1_1_0_00_0
1_0_0_00_0_0_00_0_00_0_1_10_0_0_1_1_1_10_0
2_1_1_20_0_0_00_0_11_0_0_00_0_0_1_1_0_00_0
2_0_0_00_0_0_00_0_00_0_1_20_0_0_1_2_0_00_0
2_0_0_00_0_0_00_0_00_0_0_00_0_0_1_2_0_00_0
2_0_0_00_0_0_00_0_00_0_1_11_0_0_1_2_1_11_1
3_1_1_21_0_0_00_0_12_0_0_00_0_0_1_2_0_00_0
3_1_0_00_0_1_21_0_13_0_0_00_0_0_1_3_0_00_0
3_1_1_21_0_1_22_1_14_0_1_21_0_0_1_4_0_00_0
3_0_0_00_0_0_00_0_00_0_0_00_0_0_1_5_0_00_0
3_0_0_00_0_0_00_0_00_0_0_00_0_0_1_5_1_12_2
3_0_0_00_0_0_00_0_00_0_0_00_0_0_1_5_1_13_3
3_1_1_23_0_0_00_0_15_0_0_00_0_0_1_5_1_14_4
4_1_1_24_0_0_00_0_16_0_0_00_0_0_0_6_0_00_0
4_1_1_24_0_0_00_0_16_0_1_12_0_0_0_6_0_00_0
4_1_1_24_0_0_00_0_16_0_0_00_0_0_1_6_0_00_0
4_0_0_00_0_0_00_0_00_0_1_13_0_0_0_7_0_00_0
4_0_0_00_0_0_00_0_00_0_1_14_0_0_1_7_0_00_0
5_1_1_25_0_0_00_0_17_0_0_00_0_0_1_7_0_00_0
5_1_1_25_0_0_00_0_18_0_0_00_0_0_1_8_0_00_0
5_1_1_01_1_0_00_0_19_0_0_00_1_7_0_9_0_00_0
5_1_1_01_1_0_00_0_19_0_1_25_0_0_1_8_0_00_0
5_0_0_00_0_0_00_0_00_0_0_00_0_0_0_9_0_00_0
5_0_0_00_0_0_00_0_00_0_1_23_0_0_0_9_1_17_7
5_0_0_00_0_0_00_0_00_0_1_17_0_0_0_9_1_19_8
5_0_0_00_0_0_00_0_00_0_1_19_0_0_1_9_1_15_5
6_1_1_01_1_0_00_0_1a_1_1_15_0_0_1_9_0_00_0
6_1_1_01_1_0_00_0_1b_0_0_00_0_0_1_a_0_00_0
6_0_0_00_0_0_00_0_00_0_1_24_0_0_1_b_0_00_0
6_0_0_00_0_0_00_0_00_0_0_00_0_0_1_b_1_1b_a
6_0_0_00_0_0_00_0_00_0_1_1b_0_0_1_b_1_16_6
6_0_0_00_0_0_00_0_00_0_1_16_0_0_1_b_0_00_0
6_0_0_00_0_0_00_0_00_0_0_00_0_0_1_b_0_00_0
f_0_0_00_0_0_00_0_00_0_0_00_0_0_0_0_0_00_0

//--- bench/issue_scheduler_tb.sv
`timescale 1ns/100ps
`default_nettype none

module issue_scheduler_tb
  import sched_op_pkg::*, sched_bus_pkg::*;
();

  localparam int DEPTH       = 40;
  localparam int READY_LIMIT = 8;   // cycles allowed for ready after reset

  // one line of the pattern file with every field nibble aligned
  typedef struct packed {
    logic [3:0] grp;
    logic [3:0] disp_valid;
    logic [3:0] s0_valid;
    logic [7:0] s0_tag;
    logic [3:0] s0_ready;
    logic [3:0] s1_valid;
    logic [7:0] s1_tag;
    logic [3:0] s1_ready;
    logic [7:0] dst;
    logic [3:0] dead;
    logic [3:0] wb_valid;
    logic [7:0] wb_tag;
    logic [3:0] flush_valid;
    logic [3:0] flush_seq;
    logic [3:0] exp_ready;
    logic [3:0] exp_disp_seq;
    logic [3:0] exp_valid;
    logic [7:0] exp_dst;
    logic [3:0] exp_seq;
  } pattern_t;

  logic   clk;
  logic   reset_n;
  logic   disp_valid;
  disp_t  disp;
  wb_t    wb;
  flush_t flush;
  logic   disp_ready;
  seq_t   disp_seq;
  logic   issue_valid;
  issue_t issue;

  logic [$bits(pattern_t)-1:0] patterns [DEPTH];

  int checks       = 0;
  int errors       = 0;
  int group_errors = 0;
  int tests        = 0;
  int passed       = 0;

  issue_scheduler u_dut (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_disp_valid  (disp_valid),
    .i_disp        (disp),
    .i_wb          (wb),
    .i_flush       (flush),
    .o_disp_ready  (disp_ready),
    .o_disp_seq    (disp_seq),
    .o_issue_valid (issue_valid),
    .o_issue       (issue)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // payload is opaque to the DUT, so tie it to the dst tag
  function automatic payload_t payload_of(tag_t dst);
    return {4'h9, 6'h00, dst};
  endfunction

  function automatic string group_name(logic [3:0] grp);
    case (grp)
      4'h1:    return "ready at dispatch";
      4'h2:    return "wakeup";
      4'h3:    return "age order";
      4'h4:    return "back-pressure";
      4'h5:    return "flush";
      4'h6:    return "dead dispatch";
      default: return "unknown";
    endcase
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] expected);
    $display("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, expected);
    group_errors++;
  endtask

  task automatic apply_inputs(pattern_t p);
    disp_valid        = p.disp_valid[0];
    disp.src[0].valid = p.s0_valid[0];
    disp.src[0].tag   = p.s0_tag[5:0];
    disp.src[0].ready = p.s0_ready[0];
    disp.src[1].valid = p.s1_valid[0];
    disp.src[1].tag   = p.s1_tag[5:0];
    disp.src[1].ready = p.s1_ready[0];
    disp.dst          = p.dst[5:0];
    disp.dead         = p.dead[0];
    disp.payload      = payload_of(p.dst[5:0]);
    wb.valid          = p.wb_valid[0];
    wb.tag            = p.wb_tag[5:0];
    flush.valid       = p.flush_valid[0];
    flush.seq         = p.flush_seq;
  endtask

  // outputs here still reflect the previous rising edge
  task automatic check_outputs(pattern_t p);
    issue_t exp_issue;
    exp_issue.dst     = p.exp_dst[5:0];
    exp_issue.seq     = p.exp_seq;
    exp_issue.payload = payload_of(p.exp_dst[5:0]);
    checks += 3;
    assert (disp_ready === p.exp_ready[0])
      else report_mismatch("o_disp_ready", 32'(disp_ready), 32'(p.exp_ready[0]));
    assert (disp_seq === p.exp_disp_seq)
      else report_mismatch("o_disp_seq", 32'(disp_seq), 32'(p.exp_disp_seq));
    assert (issue_valid === p.exp_valid[0])
      else report_mismatch("o_issue_valid", 32'(issue_valid), 32'(p.exp_valid[0]));
    if (p.exp_valid[0]) begin
      checks++;
      assert (issue === exp_issue)
        else report_mismatch("o_issue", 32'(issue), 32'(exp_issue));
    end
  endtask

  task automatic finish_group(logic [3:0] grp);
    tests++;
    if (group_errors == 0) begin
      passed++;
      $display("test %0d (%s): ok", grp, group_name(grp));
    end else begin
      $display("test %0d (%s): %0d errors", grp, group_name(grp), group_errors);
    end
    errors       += group_errors;
    group_errors  = 0;
  endtask

  // ----------------------------------------
  // pattern loop with one line per cycle
  // ----------------------------------------
  task automatic run_patterns();
    pattern_t   p;
    logic [3:0] cur_grp;
    int         idx;
    idx     = 0;
    p       = pattern_t'(patterns[0]);
    cur_grp = p.grp;
    while (idx < DEPTH && p.grp != 4'hf) begin
      @(negedge clk);
      check_outputs(p);
      apply_inputs(p);
      idx++;
      if (idx < DEPTH) begin
        p = pattern_t'(patterns[idx]);
        if (p.grp != cur_grp) begin
          finish_group(cur_grp);
          cur_grp = p.grp;
        end
      end
    end
  endtask

  initial begin
    int wait_cycles;
    reset_n    = 1'b0;
    disp_valid = 1'b0;
    disp       = '0;
    wb         = '0;
    flush      = '0;
    $readmemh("bench/sched_patterns.txt", patterns);
    repeat (4) @(negedge clk);
    reset_n     = 1'b1;
    wait_cycles = 0;
    while (disp_ready !== 1'b1 && wait_cycles < READY_LIMIT) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (disp_ready !== 1'b1) begin
      $display("timeout: o_disp_ready did not rise within %0d cycles of reset", READY_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end else begin
      run_patterns();
      $display("tests %0d, passed %0d, checks %0d, errors %0d", tests, passed, checks, errors);
      if (errors == 0 && checks > 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- bench/issue_scheduler_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module issue_scheduler_asserts
  import sched_op_pkg::*;
(
  input wire logic       i_clk,
  input wire logic       i_reset_n,
  input wire slot_mask_t i_grant,
  input wire slot_mask_t i_busy,
  input wire logic       i_disp_ready,
  input wire logic       i_issue_valid,
  input wire seq_t       i_issue_seq
);

  // picker hands out at most one slot per cycle
  a_grant_onehot: assert property (
    @(posedge i_clk) disable iff (!i_reset_n) $onehot0(i_grant)
  ) else $error("grant mask is not one-hot: %b", i_grant);

  // back-to-back issues must be different ops
  a_issue_single_pulse: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      i_issue_valid && $past(i_issue_valid) |-> i_issue_seq != $past(i_issue_seq)
  ) else $error("issue pulse repeated for seq %0h", i_issue_seq);

  // a full queue takes no new op
  a_full_blocks_load: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      !i_disp_ready |=> (i_busy & ~$past(i_busy)) == '0
  ) else $error("slot loaded while dispatch ready was low, busy mask %b", i_busy);

endmodule

bind issue_scheduler issue_scheduler_asserts u_asserts (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_grant       (w_grant),
  .i_busy        (w_busy),
  .i_disp_ready  (o_disp_ready),
  .i_issue_valid (o_issue_valid),
  .i_issue_seq   (o_issue.seq)
);

`default_nettype wire

//--- source/issue_scheduler.sv
`include "sched_config.svh"
`timescale 1ns/100ps
`default_nettype none

module issue_scheduler
  import sched_op_pkg::*, sched_bus_pkg::*;
(
  input  wire logic   i_clk,
  input  wire logic   i_reset_n,

  input  wire logic   i_disp_valid,
  input  wire disp_t  i_disp,
  input  wire wb_t    i_wb,
  input  wire flush_t i_flush,

  output logic        o_disp_ready,
  output seq_t        o_disp_seq,
  output logic        o_issue_valid,
  output issue_t      o_issue
);

  slot_mask_t w_load;
  slot_mask_t w_busy;
  slot_mask_t w_ready;
  slot_mask_t w_grant;
  seq_t       w_entry_seq   [`SCHED_ENTRIES];
  issue_t     w_entry_issue [`SCHED_ENTRIES];

  dispatch_seq_alloc u_alloc (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_disp_dead  (i_disp.dead),
    .i_flush      (i_flush),
    .i_busy       (w_busy),
    .o_load       (w_load),
    .o_seq        (o_disp_seq),
    .o_disp_ready (o_disp_ready)
  );

  // one FSM per slot
  for (genvar g = 0; g < `SCHED_ENTRIES; g++) begin : g_entry
    issue_entry u_entry (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_load    (w_load[g]),
      .i_disp    (i_disp),
      .i_seq     (o_disp_seq),
      .i_wb      (i_wb),
      .i_flush   (i_flush),
      .i_grant   (w_grant[g]),
      .o_ready   (w_ready[g]),
      .o_busy    (w_busy[g]),
      .o_seq     (w_entry_seq[g]),
      .o_issue   (w_entry_issue[g])
    );
  end

  age_issue_picker u_picker (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_ready       (w_ready),
    .i_seq         (w_entry_seq),
    .i_entry       (w_entry_issue),
    .i_flush       (i_flush),
    .o_grant       (w_grant),
    .o_issue_valid (o_issue_valid),
    .o_issue       (o_issue)
  );

endmodule

`default_nettype wire

//--- source/age_issue_picker.sv
`include "sched_config.svh"
`timescale 1ns/100ps
`default_nettype none

module age_issue_picker
  import sched_op_pkg::*, sched_bus_pkg::*;
(
  input  wire logic       i_clk,
  input  wire logic       i_reset_n,

  input  wire slot_mask_t i_ready,
  input  wire seq_t       i_seq   [`SCHED_ENTRIES],
  input  wire issue_t     i_entry [`SCHED_ENTRIES],
  input  wire flush_t     i_flush,

  output slot_mask_t      o_grant,
  output logic            o_issue_valid,
  output issue_t          o_issue
);

  slot_mask_t w_cand;
  issue_t     w_sel;

  // ----------------------------------------
  // oldest-first select
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < `SCHED_ENTRIES; i++) begin
      // a same-cycle flush would kill it anyway
      w_cand[i] = i_ready[i] & ~(i_flush.valid & seq_younger(i_seq[i], i_flush.seq));
    end
    for (int i = 0; i < `SCHED_ENTRIES; i++) begin
      o_grant[i] = w_cand[i];
      for (int j = 0; j < `SCHED_ENTRIES; j++) begin
        if (j != i && w_cand[j] && seq_younger(i_seq[i], i_seq[j])) o_grant[i] = 1'b0;
      end
    end
    w_sel = '0;
    for (int i = 0; i < `SCHED_ENTRIES; i++) begin
      if (o_grant[i]) w_sel = w_sel | i_entry[i];  // grant is one-hot
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) o_issue_valid <= 1'b0;
    else            o_issue_valid <= |o_grant;  // single-cycle pulse
  end

  always_ff @(posedge i_clk) begin
    o_issue <= w_sel;
  end

endmodule

`default_nettype wire

//--- source/issue_entry.sv
`timescale 1ns/100ps
`default_nettype none

module issue_entry
  import sched_op_pkg::*, sched_bus_pkg::*;
(
  input  wire logic   i_clk,
  input  wire logic   i_reset_n,

  input  wire logic   i_load,
  input  wire disp_t  i_disp,
  input  wire seq_t   i_seq,
  input  wire wb_t    i_wb,
  input  wire flush_t i_flush,
  input  wire logic   i_grant,

  output logic        o_ready,
  output logic        o_busy,
  output seq_t        o_seq,
  output issue_t      o_issue
);

  entry_state_t r_state;
  entry_state_t w_state_next;

  src_t [1:0] r_src;
  src_t [1:0] w_src_next;
  tag_t       r_dst;
  payload_t   r_payload;
  seq_t       r_seq;

  logic w_load;
  logic w_kill;
  logic w_done;
  logic w_srcs_ready;

  // operand is ready now, counting a same-cycle write-back
  function automatic logic src_woken(src_t s, wb_t wb);
    return s.ready | (wb.valid & s.valid & (s.tag == wb.tag));
  endfunction

  assign w_load = i_load & ~i_disp.dead;
  assign w_kill = i_flush.valid & seq_younger(r_seq, i_flush.seq);
  assign w_done = i_wb.valid & (i_wb.tag == r_dst);  // own result is back

  // ----------------------------------------
  // operand wakeup
  // ----------------------------------------
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      if (r_state == IDLE) begin
        w_src_next[k]       = i_disp.src[k];
        w_src_next[k].ready = src_woken(i_disp.src[k], i_wb);
      end else begin
        w_src_next[k]       = r_src[k];
        w_src_next[k].ready = src_woken(r_src[k], i_wb);
      end
    end
  end

  // ----------------------------------------
  // state machine
  // ----------------------------------------
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      IDLE: begin
        if (w_load) w_state_next = WAIT;
      end
      WAIT: begin
        if (w_kill) begin
          w_state_next = IDLE;
        end else if (i_grant) begin
          w_state_next = ISSUED;
        end
      end
      ISSUED: begin
        if (w_kill || w_done) w_state_next = IDLE;  // slot held until write-back
      end
      default: w_state_next = IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
    end else begin
      r_state <= w_state_next;
    end
  end

  always_ff @(posedge i_clk) begin
    r_src <= w_src_next;
    if (r_state == IDLE && w_load) begin
      r_dst     <= i_disp.dst;
      r_payload <= i_disp.payload;
      r_seq     <= i_seq;
    end
  end

  assign w_srcs_ready = (~r_src[0].valid | r_src[0].ready) &
                        (~r_src[1].valid | r_src[1].ready);

  assign o_ready = (r_state == WAIT) & w_srcs_ready;
  assign o_busy  = (r_state != IDLE);
  assign o_seq   = r_seq;
  assign o_issue = '{dst: r_dst, seq: r_seq, payload: r_payload};

endmodule

`default_nettype wire

//--- source/dispatch_seq_alloc.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_seq_alloc
  import sched_op_pkg::*, sched_bus_pkg::*;
(
  input  wire logic       i_clk,
  input  wire logic       i_reset_n,

  input  wire logic       i_disp_valid,
  input  wire logic       i_disp_dead,
  input  wire flush_t     i_flush,
  input  wire slot_mask_t i_busy,

  output slot_mask_t      o_load,
  output seq_t            o_seq,
  output logic            o_disp_ready
);

  seq_t       r_next_seq;
  slot_mask_t w_free;
  slot_mask_t w_lowest_free;
  logic       w_accept;
  logic       w_take_slot;

  // ----------------------------------------
  // slot choice
  // ----------------------------------------
  assign w_free        = ~i_busy;
  assign w_lowest_free = w_free & (~w_free + slot_mask_t'(1));  // isolate lowest set bit

  assign o_disp_ready  = |w_free;

  // a same-cycle flush drops the dispatch
  assign w_accept    = i_disp_valid & o_disp_ready & ~i_flush.valid;
  assign w_take_slot = w_accept & ~i_disp_dead;  // dead ops only burn a seq

  assign o_load = w_take_slot ? w_lowest_free : '0;
  assign o_seq  = r_next_seq;

  // ----------------------------------------
  // sequence counter
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_next_seq <= '0;
    end else if (i_flush.valid) begin
      r_next_seq <= i_flush.seq + seq_t'(1);  // rewind past the surviving ops
    end else if (w_accept) begin
      r_next_seq <= r_next_seq + seq_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- source/sched_bus_pkg.sv
`default_nettype none

package sched_bus_pkg;

  import sched_op_pkg::*;

  // result broadcast of one tag per cycle
  typedef struct packed {
    logic valid;
    tag_t tag;
  } wb_t;

  // kills everything strictly younger than seq
  typedef struct packed {
    logic valid;
    seq_t seq;
  } flush_t;

endpackage

`default_nettype wire

//--- source/sched_op_pkg.sv
`include "sched_config.svh"
`default_nettype none

package sched_op_pkg;

  typedef logic [`SCHED_TAG_W-1:0]     tag_t;
  typedef logic [`SCHED_SEQ_W-1:0]     seq_t;
  typedef logic [`SCHED_ENTRIES-1:0]   slot_mask_t;
  typedef logic [`SCHED_PAYLOAD_W-1:0] payload_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
    logic ready;   // already produced
  } src_t;

  typedef struct packed {
    src_t [1:0] src;
    tag_t       dst;
    logic       dead;  // arrives killed, never issues
    payload_t   payload;
  } disp_t;

  typedef struct packed {
    tag_t     dst;
    seq_t     seq;
    payload_t payload;
  } issue_t;

  typedef enum logic [1:0] {IDLE, WAIT, ISSUED} entry_state_t;

  // a is younger than b, modulo the seq wrap
  function automatic logic seq_younger(seq_t a, seq_t b);
    logic signed [`SCHED_SEQ_W-1:0] diff;
    diff = a - b;
    return diff > 0;
  endfunction

endpackage

`default_nettype wire

//--- source/sched_config.svh
`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

`default_nettype none

`define SCHED_ENTRIES    4   // scheduler slots
`define SCHED_TAG_W      6   // physical register tag
`define SCHED_SEQ_W      4   // at least log2(entries) + 1 for wrapped compares
`define SCHED_PAYLOAD_W  16  // opaque op bits

`default_nettype wire

`endif
